// File: outrun_video_defs.svh
/*
 Screen geometry, tile map size and interrupt spacing.
 Pixel counts are in pxl_cen periods, line counts in lines.
 Blanking and sync positions must stay inside the totals.
 H_TOTAL must be a multiple of the 8 pixel tile width.
*/
`ifndef OUTRUN_VIDEO_DEFS_SVH
`define OUTRUN_VIDEO_DEFS_SVH

// Horizontal timing in pixels
`define H_TOTAL       96
`define H_ACTIVE      64
`define HS_START      72
`define HS_END        80

// Vertical timing in lines
`define V_TOTAL       40
`define V_ACTIVE      32
`define VS_START      34
`define VS_END        36

// Tile map, 8x8 pixel tiles
`define MAP_COLS      8
`define MAP_ROWS      4

// Line interrupt every this many lines
`define LINE_IRQ_STEP 8

// Graphics ROM address, 9 bit code then 3 bit row
`define ROM_AW        12

`endif

// File: outrun_video_pkg.sv
/*
 Types shared by the video blocks.
 Positions are limited to 7 bit h and 6 bit v, which covers
 the reduced 96x40 total raster only.
 The palette word is one 16 bit word seen raw by the CPU and
 as 5 bit colour fields by the mixer.
*/
package outrun_video_pkg;

    // Raster position with its blanking flags
    typedef struct packed {
        logic [6:0] h;
        logic [5:0] v;
        logic       lhbl;
        logic       lvbl;
    } pxl_pos_t;

    // One character RAM word
    typedef struct packed {
        logic [8:0] code;
        logic [2:0] bank;
        logic [3:0] unused;
    } map_entry_t;

    // Colour fields of a palette word, red in the low bits
    typedef struct packed {
        logic       unused;
        logic [4:0] blue;
        logic [4:0] green;
        logic [4:0] red;
    } pal_rgb_t;

    typedef union packed {
        logic [15:0] raw;
        pal_rgb_t    rgb;
    } pal_word_u;

    // CPU bus, word addressed with active low byte strobes
    typedef struct packed {
        logic [6:0]  addr;
        logic [15:0] dout;
        logic [1:0]  dswn;
    } cpu_bus_t;

    // Palette bank followed by the 4 bit pixel
    typedef logic [6:0] pal_idx_t;

endpackage

// File: video_timing.sv
/*
 Raster counters for the reduced screen.
 All counting happens on pxl_cen only.
 Blanking and sync come straight from the counters, so they
 line up with pos on the same cycle.
*/
`timescale 1ns/100ps
`include "outrun_video_defs.svh"

module video_timing (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pxl_cen,
    output outrun_video_pkg::pxl_pos_t pos,
    output logic                       hs,
    output logic                       vs
);

    logic [6:0] hcnt;
    logic [5:0] vcnt;
    logic       h_last;
    logic       v_last;

    assign h_last = hcnt == 7'(`H_TOTAL - 1);
    assign v_last = vcnt == 6'(`V_TOTAL - 1);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hcnt <= 7'd0;
            vcnt <= 6'd0;
        end else if (pxl_cen) begin
            if (h_last) begin
                hcnt <= 7'd0;
                // Line done, move down or restart the frame
                if (v_last) begin
                    vcnt <= 6'd0;
                end else begin
                    vcnt <= vcnt + 6'd1;
                end
            end else begin
                hcnt <= hcnt + 7'd1;
            end
        end
    end

    assign pos.h    = hcnt;
    assign pos.v    = vcnt;
    assign pos.lhbl = hcnt < 7'(`H_ACTIVE);
    assign pos.lvbl = vcnt < 6'(`V_ACTIVE);

    // Sync pulses, high active
    assign hs = (hcnt >= 7'(`HS_START)) && (hcnt < 7'(`HS_END));
    assign vs = (vcnt >= 6'(`VS_START)) && (vcnt < 6'(`VS_END));

    // Wrap must happen exactly at the total
    a_h_range: assert property (
        @(posedge clk) disable iff (rst)
        hcnt < 7'(`H_TOTAL)
    );

endmodule

// File: char_layer.sv
/*
 Character tilemap layer, 8x4 map of 8x8 tiles.
 Pixel output trails pos_in by exactly 2 pxl_cen.
 One tile row is fetched ahead from the graphics ROM; the address
 is held until char_ok, and char_ok must be a one clock pulse.
 A row missing at its tile boundary shows pixel 0 and sets the
 sticky rom_late flag. The first tile after reset is never fetched.
*/
`timescale 1ns/100ps
`include "outrun_video_defs.svh"

module char_layer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pxl_cen,
    input  logic                       char_cs,
    input  outrun_video_pkg::cpu_bus_t cpu,
    output logic [15:0]                char_dout,
    input  outrun_video_pkg::pxl_pos_t pos_in,
    output logic [`ROM_AW-1:0]         char_addr,
    input  logic [31:0]                char_data,
    input  logic                       char_ok,
    output outrun_video_pkg::pal_idx_t pix,
    output outrun_video_pkg::pxl_pos_t pos_out,
    output logic                       rom_late
);

    import outrun_video_pkg::*;

    localparam int MAP_AW = $clog2(`MAP_COLS * `MAP_ROWS);

    logic [15:0]       char_ram [`MAP_COLS * `MAP_ROWS];
    logic [MAP_AW-1:0] cpu_addr;
    logic [MAP_AW-1:0] map_addr;
    map_entry_t        map_q;

    pxl_pos_t    pos_d1;
    logic        tile_start;
    logic [6:0]  nxt_h;
    logic [5:0]  nxt_v;
    logic [2:0]  fetch_row;

    logic [1:0]  map_phase;
    logic        issue_wait;
    logic        issue;
    logic        req_pend;
    logic        stale;
    logic        row_valid;
    logic        primed;
    logic [2:0]  bank_pend;
    logic [31:0] next_row;
    logic [2:0]  next_bank;
    logic [31:0] shift;
    logic [2:0]  cur_bank;

    assign cpu_addr = cpu.addr[MAP_AW-1:0];

    // CPU port with byte writes, plus the video read port
    always_ff @(posedge clk) begin
        if (char_cs && !cpu.dswn[0]) begin
            char_ram[cpu_addr][7:0] <= cpu.dout[7:0];
        end
        if (char_cs && !cpu.dswn[1]) begin
            char_ram[cpu_addr][15:8] <= cpu.dout[15:8];
        end
        if (char_cs && (&cpu.dswn)) begin
            char_dout <= char_ram[cpu_addr];
        end
        map_q <= char_ram[map_addr];
    end

    assign tile_start = pxl_cen && (pos_d1.h[2:0] == 3'd0);

    // Position of the tile after the one now starting
    always_comb begin
        nxt_h = pos_d1.h + 7'd8;
        nxt_v = pos_d1.v;
        if (nxt_h >= 7'(`H_TOTAL)) begin
            nxt_h = nxt_h - 7'(`H_TOTAL);
            nxt_v = (pos_d1.v == 6'(`V_TOTAL - 1)) ? 6'd0 : pos_d1.v + 6'd1;
        end
    end

    assign issue = issue_wait && !req_pend;

    // Map read takes two clocks before the ROM request
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            map_phase  <= 2'd0;
            issue_wait <= 1'b0;
            req_pend   <= 1'b0;
            stale      <= 1'b0;
            row_valid  <= 1'b0;
            primed     <= 1'b0;
            char_addr  <= '0;
            rom_late   <= 1'b0;
        end else begin
            map_phase <= {map_phase[0], tile_start};
            if (map_phase[1]) begin
                issue_wait <= 1'b1;
            end
            // Late rows only count once a request has gone out
            if (issue) begin
                issue_wait <= 1'b0;
                req_pend   <= 1'b1;
                primed     <= 1'b1;
                char_addr  <= {map_q.code, fetch_row};
            end
            if (req_pend && char_ok) begin
                req_pend  <= 1'b0;
                stale     <= 1'b0;
                row_valid <= !stale;
            end
            // Boundary consumes the row and drops late data
            if (tile_start) begin
                row_valid <= 1'b0;
                if (primed && !row_valid) begin
                    rom_late <= 1'b1;
                end
                if (req_pend && !char_ok) begin
                    stale <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tile_start) begin
            map_addr  <= MAP_AW'(nxt_v[5:3] * `MAP_COLS + nxt_h[6:3]);
            fetch_row <= nxt_v[2:0];
        end
        if (issue) begin
            bank_pend <= map_q.bank;
        end
        if (req_pend && char_ok && !stale) begin
            next_row  <= char_data;
            next_bank <= bank_pend;
        end
    end

    // Position pipeline with the blanking flags
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pos_d1  <= '0;
            pos_out <= '0;
        end else if (pxl_cen) begin
            pos_d1  <= pos_in;
            pos_out <= pos_d1;
        end
    end

    // Leftmost pixel sits in the top nibble
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (tile_start) begin
                shift    <= row_valid ? {next_row[27:0], 4'd0} : 32'd0;
                cur_bank <= row_valid ? next_bank : 3'd0;
                pix      <= row_valid ? {next_bank, next_row[31:28]} : 7'd0;
            end else begin
                shift <= {shift[27:0], 4'd0};
                pix   <= {cur_bank, shift[31:28]};
            end
        end
    end

    // ROM side must honour the hold rule and answer only requests
    a_addr_hold: assert property (
        @(posedge clk) disable iff (rst)
        (req_pend && !char_ok) |=> $stable(char_addr)
    );

    a_ok_pending: assert property (
        @(posedge clk) disable iff (rst)
        char_ok |-> req_pend
    );

endmodule

// File: colmix.sv
/*
 Colour mixer with 128 entry palette RAM.
 Output colour trails pix by exactly 1 pxl_cen.
 The CPU sees each entry as a raw 16 bit word; pixel value 0 is
 looked up like any other, there is no transparency here.
 RGB is zero whenever out_pos is in blanking.
*/
`timescale 1ns/100ps

module colmix (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pxl_cen,
    input  logic                       pal_cs,
    input  outrun_video_pkg::cpu_bus_t cpu,
    output logic [15:0]                pal_dout,
    input  outrun_video_pkg::pal_idx_t pix,
    input  outrun_video_pkg::pxl_pos_t pos_in,
    output logic [4:0]                 red,
    output logic [4:0]                 green,
    output logic [4:0]                 blue,
    output outrun_video_pkg::pxl_pos_t out_pos
);

    import outrun_video_pkg::*;

    pal_word_u pal_ram [128];
    pal_word_u pal_q;
    logic      visible;

    // CPU port, byte masked through the raw view
    always_ff @(posedge clk) begin
        if (pal_cs && !cpu.dswn[0]) begin
            pal_ram[cpu.addr].raw[7:0] <= cpu.dout[7:0];
        end
        if (pal_cs && !cpu.dswn[1]) begin
            pal_ram[cpu.addr].raw[15:8] <= cpu.dout[15:8];
        end
        if (pal_cs && (&cpu.dswn)) begin
            pal_dout <= pal_ram[cpu.addr].raw;
        end
    end

    // Pixel lookup
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pal_q <= pal_ram[pix];
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            out_pos <= '0;
        end else if (pxl_cen) begin
            out_pos <= pos_in;
        end
    end

    assign visible = out_pos.lhbl && out_pos.lvbl;

    // Split through the colour fields, black in blanking
    assign red   = visible ? pal_q.rgb.red   : 5'd0;
    assign green = visible ? pal_q.rgb.green : 5'd0;
    assign blue  = visible ? pal_q.rgb.blue  : 5'd0;

endmodule

// File: outrun_video.sv
/*
 Video top level: timing, character layer and colour mixer.
 RGB and out_pos trail the raster counters by 3 pxl_cen.
 hs and vs follow the counters directly, not the RGB output.
 Interrupts act on the counter position: line_intn is active low
 and held through the blanking, vint is a one pxl_cen pulse.
*/
`timescale 1ns/100ps
`include "outrun_video_defs.svh"

module outrun_video (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pxl_cen,
    input  logic                       char_cs,
    input  logic                       pal_cs,
    input  outrun_video_pkg::cpu_bus_t cpu,
    output logic [15:0]                char_dout,
    output logic [15:0]                pal_dout,
    output logic [`ROM_AW-1:0]         char_addr,
    input  logic [31:0]                char_data,
    input  logic                       char_ok,
    output logic                       hs,
    output logic                       vs,
    output outrun_video_pkg::pxl_pos_t out_pos,
    output logic [4:0]                 red,
    output logic [4:0]                 green,
    output logic [4:0]                 blue,
    output logic                       vint,
    output logic                       line_intn,
    output logic                       rom_late
);

    import outrun_video_pkg::*;

    pxl_pos_t pos;
    pxl_pos_t char_pos;
    pal_idx_t char_pix;
    logic     lhbl_l;
    logic     lvbl_l;
    logic     irq_line;

    // Non-zero multiples of the step inside the visible lines
    assign irq_line = (pos.v != 6'd0) && (pos.v < 6'(`V_ACTIVE))
                      && ((pos.v % 6'(`LINE_IRQ_STEP)) == 6'd0);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            line_intn <= 1'b1;
            vint      <= 1'b0;
            lhbl_l    <= 1'b0;
            lvbl_l    <= 1'b0;
        end else if (pxl_cen) begin
            lhbl_l <= pos.lhbl;
            lvbl_l <= pos.lvbl;
            if (!pos.lhbl && lhbl_l && irq_line) begin
                line_intn <= 1'b0;
            end
            if (pos.lhbl) begin
                line_intn <= 1'b1;
            end
            // one pxl_cen wide, at the start of vertical blanking
            vint <= lvbl_l && !pos.lvbl;
        end
    end

    video_timing u_timing (
        .clk     ( clk      ),
        .rst     ( rst      ),
        .pxl_cen ( pxl_cen  ),
        .pos     ( pos      ),
        .hs      ( hs       ),
        .vs      ( vs       )
    );

    char_layer u_char (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .pxl_cen   ( pxl_cen   ),
        .char_cs   ( char_cs   ),
        .cpu       ( cpu       ),
        .char_dout ( char_dout ),
        .pos_in    ( pos       ),
        .char_addr ( char_addr ),
        .char_data ( char_data ),
        .char_ok   ( char_ok   ),
        .pix       ( char_pix  ),
        .pos_out   ( char_pos  ),
        .rom_late  ( rom_late  )
    );

    colmix u_colmix (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .pal_cs   ( pal_cs   ),
        .cpu      ( cpu      ),
        .pal_dout ( pal_dout ),
        .pix      ( char_pix ),
        .pos_in   ( char_pos ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .out_pos  ( out_pos  )
    );

endmodule

// File: outrun_video_tb.sv
/*
 Testbench for the reduced video top level.
 The ROM model answers each request 1 to 3 clocks late, with data hashed
 from the address. The layer therefore must never run late.
 Colour, line_intn, vint, hs and vs are checked against out_pos over one frame.
 The expected windows assume the 3 pxl_cen counter to RGB latency.
*/
`timescale 1ns/100ps
`include "outrun_video_defs.svh"

module outrun_video_tb;

    import outrun_video_pkg::*;

    localparam int TILE          = 8;
    localparam int MAP_N         = `MAP_COLS * `MAP_ROWS;
    localparam int PAL_N         = 128;
    localparam int FRAME_PIX     = `H_TOTAL * `V_TOTAL;
    localparam int N_ACC         = 18;
    localparam int WATCHDOG_CLKS = 16 + 2 * N_ACC + 2 * (MAP_N + PAL_N) + 3 * 2 * FRAME_PIX;

    // One CPU access and the value a read must return
    typedef struct packed {
        logic        pal;
        logic [6:0]  addr;
        logic [15:0] data;
        logic [1:0]  dswn;
        logic [15:0] exp;
    } access_t;

    logic               clk;
    logic               rst;
    logic               pxl_cen;
    logic               char_cs;
    logic               pal_cs;
    cpu_bus_t           cpu;
    logic [15:0]        char_dout;
    logic [15:0]        pal_dout;
    logic [`ROM_AW-1:0] char_addr;
    logic [31:0]        char_data;
    logic               char_ok;
    logic               hs;
    logic               vs;
    pxl_pos_t           out_pos;
    logic [4:0]         red;
    logic [4:0]         green;
    logic [4:0]         blue;
    logic               vint;
    logic               line_intn;
    logic               rom_late;

    access_t     acc_tab [N_ACC];
    map_entry_t  map_model [MAP_N];
    pal_word_u   pal_model [PAL_N];
    int          n_checks = 0;
    int          n_errors = 0;
    int          rom_wait;
    logic [31:0] rom_rnd;

    outrun_video i_dut (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .pxl_cen   ( pxl_cen   ),
        .char_cs   ( char_cs   ),
        .pal_cs    ( pal_cs    ),
        .cpu       ( cpu       ),
        .char_dout ( char_dout ),
        .pal_dout  ( pal_dout  ),
        .char_addr ( char_addr ),
        .char_data ( char_data ),
        .char_ok   ( char_ok   ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .out_pos   ( out_pos   ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      ),
        .vint      ( vint      ),
        .line_intn ( line_intn ),
        .rom_late  ( rom_late  )
    );

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Graphics ROM contents, a hash of the address
    function automatic logic [31:0] rom_word(logic [`ROM_AW-1:0] a);
        return xorshift32(xorshift32(32'heb16 ^ {20'd0, a}));
    endfunction

    // Colour of a visible pixel from the model map, ROM and palette
    function automatic pal_word_u expected_colour(int h, int v);
        map_entry_t  entry;
        logic [31:0] row;
        logic [3:0]  nib;
        pal_idx_t    idx;
        entry = map_model[(v / TILE) * `MAP_COLS + h / TILE];
        row   = rom_word({entry.code, 3'(v % TILE)});
        // Leftmost pixel in the top nibble
        nib   = 4'(row >> (28 - 4 * (h % TILE)));
        idx   = {entry.bank, nib};
        return pal_model[idx];
    endfunction

    // Low from one pxl_cen after lhbl falls until one after it rises
    // as seen at out_pos, which lags the counters by 3
    function automatic logic exp_line_intn(int h, int v);
        if (v != 0 && v < `V_ACTIVE && (v % `LINE_IRQ_STEP) == 0
            && h >= `H_ACTIVE - 2 && h <= `H_TOTAL - 3) begin
            return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic check_word(string name, logic [15:0] exp, logic [15:0] got);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic check_rgb(pal_word_u exp, int h, int v);
        n_checks++;
        if (red !== exp.rgb.red || green !== exp.rgb.green || blue !== exp.rgb.blue) begin
            n_errors++;
            $display("MISMATCH rgb at h=%0d v=%0d: expected %h %h %h, got %h %h %h",
                     h, v, exp.rgb.red, exp.rgb.green, exp.rgb.blue, red, green, blue);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic got);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic check_pos(pxl_pos_t exp, pxl_pos_t got);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH out_pos: expected %h, got %h", exp, got);
        end
    endtask

    // Step to just after the next pxl_cen edge
    task automatic next_pixel();
        @(posedge clk);
        while (!pxl_cen) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    // Single cycle strobe with read data valid at the closing edge
    task automatic cpu_access(access_t a);
        @(negedge clk);
        char_cs  = !a.pal;
        pal_cs   = a.pal;
        cpu.addr = a.addr;
        cpu.dout = a.data;
        cpu.dswn = a.dswn;
        @(negedge clk);
        char_cs  = 1'b0;
        pal_cs   = 1'b0;
        cpu.dswn = 2'b11;
    endtask

    task automatic load_table();
        acc_tab[0]  = '{1'b0, 7'd5,   16'h1234, 2'b00, 16'h0000};
        acc_tab[1]  = '{1'b0, 7'd5,   16'h0000, 2'b11, 16'h1234};
        acc_tab[2]  = '{1'b0, 7'd5,   16'habcd, 2'b10, 16'h0000};
        acc_tab[3]  = '{1'b0, 7'd5,   16'h0000, 2'b11, 16'h12cd};
        acc_tab[4]  = '{1'b0, 7'd5,   16'hef00, 2'b01, 16'h0000};
        acc_tab[5]  = '{1'b0, 7'd5,   16'h0000, 2'b11, 16'hefcd};
        acc_tab[6]  = '{1'b0, 7'd31,  16'h0f0f, 2'b00, 16'h0000};
        acc_tab[7]  = '{1'b0, 7'd31,  16'h0000, 2'b11, 16'h0f0f};
        acc_tab[8]  = '{1'b0, 7'd5,   16'h0000, 2'b11, 16'hefcd};
        acc_tab[9]  = '{1'b1, 7'd100, 16'h7fff, 2'b00, 16'h0000};
        acc_tab[10] = '{1'b1, 7'd100, 16'h0000, 2'b11, 16'h7fff};
        acc_tab[11] = '{1'b1, 7'd100, 16'h1234, 2'b10, 16'h0000};
        acc_tab[12] = '{1'b1, 7'd100, 16'h0000, 2'b11, 16'h7f34};
        acc_tab[13] = '{1'b1, 7'd100, 16'ha500, 2'b01, 16'h0000};
        acc_tab[14] = '{1'b1, 7'd100, 16'h0000, 2'b11, 16'ha534};
        acc_tab[15] = '{1'b1, 7'd69,  16'h8001, 2'b00, 16'h0000};
        acc_tab[16] = '{1'b1, 7'd69,  16'h0000, 2'b11, 16'h8001};
        // Palette writes leave the character RAM alone
        acc_tab[17] = '{1'b0, 7'd5,   16'h0000, 2'b11, 16'hefcd};
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Pixel enable on every second clock
    initial begin
        pxl_cen = 1'b0;
        forever begin
            @(negedge clk);
            pxl_cen <= ~pxl_cen;
        end
    end

    // ROM model that answers the layer's pending request
    initial begin
        char_ok   = 1'b0;
        char_data = 32'd0;
        rom_wait  = 0;
        rom_rnd   = 32'heb16;
        forever begin
            @(negedge clk);
            if (char_ok) begin
                char_ok = 1'b0;
            end else if (rom_wait > 0) begin
                rom_wait = rom_wait - 1;
                if (rom_wait == 0) begin
                    char_data = rom_word(char_addr);
                    char_ok   = 1'b1;
                end
            end else if (i_dut.u_char.req_pend) begin
                rom_rnd  = xorshift32(rom_rnd);
                rom_wait = 1 + int'(rom_rnd % 32'd3);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        $display("watchdog expired after %0d clocks, tests did not finish", WATCHDOG_CLKS);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int          errs;
        int          gap;
        int          pulses;
        int          eh;
        int          ev;
        int          ch;
        int          cv;
        logic [31:0] fill_rnd;
        access_t     acc;
        pxl_pos_t    exp_pos;
        pal_word_u   exp_col;

        rst      = 1'b1;
        char_cs  = 1'b0;
        pal_cs   = 1'b0;
        cpu      = '{addr: 7'd0, dout: 16'd0, dswn: 2'b11};
        load_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < N_ACC; i++) begin
            errs = n_errors;
            cpu_access(acc_tab[i]);
            if (&acc_tab[i].dswn) begin
                check_word(acc_tab[i].pal ? "pal_dout" : "char_dout", acc_tab[i].exp,
                           acc_tab[i].pal ? pal_dout : char_dout);
            end
            $display("access %0d (%s, addr %h, dswn %b): %s", i,
                     acc_tab[i].pal ? "palette" : "char", acc_tab[i].addr,
                     acc_tab[i].dswn, (n_errors == errs) ? "ok" : "failed");
        end

        // Known map and palette for the frame scan
        fill_rnd = 32'heb16;
        for (int i = 0; i < MAP_N + PAL_N; i++) begin
            fill_rnd = xorshift32(fill_rnd);
            acc.pal  = i >= MAP_N;
            acc.addr = acc.pal ? 7'(i - MAP_N) : 7'(i);
            acc.data = acc.pal ? fill_rnd[31:16] : fill_rnd[15:0];
            acc.dswn = 2'b00;
            acc.exp  = 16'h0000;
            if (acc.pal) begin
                pal_model[acc.addr].raw = acc.data;
            end else begin
                map_model[acc.addr[4:0]] = map_entry_t'(acc.data);
            end
            cpu_access(acc);
        end
        $display("fill: %0d map and %0d palette words written", MAP_N, PAL_N);

        // The first tile of the next frame is fetched after this vint
        do begin
            next_pixel();
        end while (vint !== 1'b1);
        gap = 0;
        do begin
            next_pixel();
            gap++;
        end while (out_pos.h != 7'd0 || out_pos.v != 6'd0);

        errs   = n_errors;
        pulses = 0;
        for (int k = 0; k < FRAME_PIX; k++) begin
            if (k > 0) begin
                next_pixel();
                gap++;
            end
            eh           = k % `H_TOTAL;
            ev           = k / `H_TOTAL;
            exp_pos.h    = 7'(eh);
            exp_pos.v    = 6'(ev);
            exp_pos.lhbl = eh < `H_ACTIVE;
            exp_pos.lvbl = ev < `V_ACTIVE;
            check_pos(exp_pos, out_pos);
            if (exp_pos.lhbl && exp_pos.lvbl) begin
                exp_col = expected_colour(eh, ev);
            end else begin
                exp_col.raw = 16'h0000;
            end
            check_rgb(exp_col, eh, ev);
            check_flag($sformatf("line_intn at h=%0d v=%0d", eh, ev),
                       exp_line_intn(eh, ev), line_intn);
            // vint rises 2 pixels before lvbl falls at out_pos
            check_flag($sformatf("vint at h=%0d v=%0d", eh, ev),
                       (eh == `H_TOTAL - 2) && (ev == `V_ACTIVE - 1), vint);
            // Sync follows the counters, 3 pixels ahead of out_pos
            ch = (k + 3) % `H_TOTAL;
            cv = ((k + 3) / `H_TOTAL) % `V_TOTAL;
            check_flag($sformatf("hs at h=%0d v=%0d", eh, ev),
                       (ch >= `HS_START) && (ch < `HS_END), hs);
            check_flag($sformatf("vs at h=%0d v=%0d", eh, ev),
                       (cv >= `VS_START) && (cv < `VS_END), vs);
            if (vint === 1'b1) begin
                pulses++;
                if (gap != FRAME_PIX) begin
                    n_errors++;
                    $display("vint period was %0d pixels instead of %0d", gap, FRAME_PIX);
                end
                gap = 0;
            end
        end
        if (pulses != 1) begin
            n_errors++;
            $display("vint pulsed %0d times in one frame instead of once", pulses);
        end
        $display("frame scan: %0d positions, %s", FRAME_PIX, (n_errors == errs) ? "ok" : "failed");

        errs = n_errors;
        check_flag("rom_late", 1'b0, rom_late);
        $display("rom_late: %s", (n_errors == errs) ? "ok" : "failed");

        $display("done: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: outrun_video.f
+incdir+.
outrun_video_pkg.sv
video_timing.sv
char_layer.sv
colmix.sv
outrun_video.sv
outrun_video_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the video testbench with Verilator.
# Exit status is non-zero if the build fails, the run aborts,
# or the log holds the fail message.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f outrun_video.f \
    --top-module outrun_video_tb -o outrun_video_sim \
    && ./obj_dir/outrun_video_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0
